// File: verilog/pitaya_cfg.svh
// Build-time widths and constants for the ADC/DAC signal path and register bus.
// Included by the package and by every module that sizes its ports from it.
`ifndef PITAYA_CFG_SVH
`define PITAYA_CFG_SVH

////////////////////////////////////////////////////////////
// sample path
////////////////////////////////////////////////////////////

`define ADC_DW      14            // ADC and DAC sample width
`define NS_ZERO     14'h1FFF      // negative-slope offset binary code for 0

////////////////////////////////////////////////////////////
// Wishbone bus and region decode
////////////////////////////////////////////////////////////

`define BUS_AW      32            // byte address
`define BUS_DW      32            // data word
`define REGION_HI   22            // region select msb
`define REGION_LO   20            // region select lsb, 1 MB per region
`define N_REGIONS   8

////////////////////////////////////////////////////////////
// register contents
////////////////////////////////////////////////////////////

`define LED_W       8
`define KP_W        12            // signed gain
`define KP_SHIFT    8             // product scaling, gain 256 is unity
`define HK_ID_VAL   32'h0000_0001 // board id word

`endif

// File: verilog/pitaya_pkg.sv
// Shared sample types, register offset maps and small helpers.
// Modules pull these in with a wildcard import in their header.
`include "pitaya_cfg.svh"

package pitaya_pkg;

  typedef logic signed [`ADC_DW-1:0] adc_smp_t; // two's complement sample
  typedef logic signed [`ADC_DW:0]   dac_sum_t; // sample plus one guard bit

  // housekeeping offsets, region 0
  typedef enum logic [`REGION_LO-1:0] {
    HK_ID   = 20'h00,  // read only
    HK_LOOP = 20'h04,  // bit 0 digital loopback
    HK_LED  = 20'h08,
    HK_DC_A = 20'h0C,  // signed DC level
    HK_DC_B = 20'h10
  } hk_reg_e;

  // proportional controller offsets, region 1
  typedef enum logic [`REGION_LO-1:0] {
    CTRL_SP_A = 20'h00,
    CTRL_SP_B = 20'h04,
    CTRL_KP_A = 20'h08,
    CTRL_KP_B = 20'h0C
  } ctrl_reg_e;

  // negative-slope offset binary <-> two's complement, same bit flip both ways
  function automatic logic [`ADC_DW-1:0] ns_flip(input logic [`ADC_DW-1:0] d);
    return {d[`ADC_DW-1], ~d[`ADC_DW-2:0]};
  endfunction

  // byte-enable merge of a write onto the current register word
  function automatic logic [`BUS_DW-1:0] be_merge(
    input logic [`BUS_DW-1:0]   cur,
    input logic [`BUS_DW-1:0]   wdat,
    input logic [`BUS_DW/8-1:0] sel
  );
    logic [`BUS_DW-1:0] res;
    res = cur;
    for (int b = 0; b < `BUS_DW/8; b++)
      if (sel[b])
        res[8*b +: 8] = wdat[8*b +: 8]; // lane taken from master
    return res;
  endfunction

endpackage

// File: verilog/sys_bus_decoder.sv
// Wishbone classic region decoder. Splits the address space into 1 MB regions,
// fans the strobe out to the two live slaves and returns their ack and data.
// Unused regions are acked here and read as zero.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module sys_bus_decoder (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic [`BUS_AW-1:0]          wb_adr_i,
  input  logic [1:0]                  slv_ack_i,    // region 1, region 0
  input  logic [1:0][`BUS_DW-1:0]     slv_rdata_i,
  output logic [1:0]                  slv_stb_o,
  output logic [`BUS_DW-1:0]          wb_dat_o,
  output logic                        wb_ack_o
);

  localparam int RW    = `REGION_HI - `REGION_LO + 1; // region index width
  localparam int N_SLV = 2;                           // live slaves

  logic [RW-1:0]         region;
  logic [`N_REGIONS-1:0] region_oh;  // one-hot region select
  logic                  bus_req;    // cyc and stb together
  logic                  void_hit;   // address in an unused region
  logic                  void_ack;
  logic [`N_REGIONS-1:0] ack_vec;

  assign region    = wb_adr_i[`REGION_HI:`REGION_LO];
  assign region_oh = `N_REGIONS'(1) << region;
  assign bus_req   = wb_cyc_i & wb_stb_i;

  assign slv_stb_o = region_oh[N_SLV-1:0] & {N_SLV{bus_req}};
  assign void_hit  = |region_oh[`N_REGIONS-1:N_SLV];

  // dummy slave for regions 2..7, same one-cycle registered ack
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      void_ack <= 1'b0;
    else
      void_ack <= bus_req & void_hit & ~void_ack; // drops after one cycle
  end

  // ack back by held region
  assign ack_vec  = {{(`N_REGIONS-N_SLV){void_ack}}, slv_ack_i};
  assign wb_ack_o = |(region_oh & ack_vec);

  // read data, zero unless a live slave is addressed
  always_comb
  begin
    wb_dat_o = '0;
    for (int i = 0; i < N_SLV; i++)
      if (region_oh[i])
        wb_dat_o = slv_rdata_i[i];
  end

endmodule

// File: verilog/housekeeping.sv
// Region 0 board configuration: LEDs, digital loopback and per-channel DC level.
// Byte-enabled writes, registered ack one cycle after the strobe.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module housekeeping
  import pitaya_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [`BUS_AW-1:0]    adr_i,
  input  logic [`BUS_DW/8-1:0]  sel_i,
  input  logic [`BUS_DW-1:0]    dat_i,
  output logic [`BUS_DW-1:0]    dat_o,
  output logic                  ack_o,
  output logic [`LED_W-1:0]     led_o,
  output logic                  loop_en_o,
  output adc_smp_t              dc_a_o,
  output adc_smp_t              dc_b_o
);

  hk_reg_e            offs;    // word offset within region
  logic               acc;     // first cycle of an access
  logic [`BUS_DW-1:0] rd_mux;  // current value at offs
  logic [`BUS_DW-1:0] wr_val;  // rd_mux with written lanes replaced

  assign offs = hk_reg_e'(adr_i[`REGION_LO-1:0]);
  assign acc  = stb_i & ~ack_o;

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_mux = '0;
    case (offs)
      HK_ID   : rd_mux = `HK_ID_VAL;
      HK_LOOP : rd_mux[0] = loop_en_o;
      HK_LED  : rd_mux[`LED_W-1:0] = led_o;
      HK_DC_A : rd_mux = {{(`BUS_DW-`ADC_DW){dc_a_o[`ADC_DW-1]}}, dc_a_o}; // sign ext
      HK_DC_B : rd_mux = {{(`BUS_DW-`ADC_DW){dc_b_o[`ADC_DW-1]}}, dc_b_o};
      default : rd_mux = '0;  // unknown offset
    endcase
  end

  assign wr_val = be_merge(rd_mux, dat_i, sel_i);

  ////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o     <= 1'b0;
      loop_en_o <= 1'b0;
      led_o     <= '0;
      dc_a_o    <= '0;
      dc_b_o    <= '0;
    end
    else
    begin
      ack_o <= acc;
      if (acc && we_i)
      begin
        case (offs)
          HK_LOOP : loop_en_o <= wr_val[0];
          HK_LED  : led_o     <= wr_val[`LED_W-1:0];
          HK_DC_A : dc_a_o    <= wr_val[`ADC_DW-1:0];
          HK_DC_B : dc_b_o    <= wr_val[`ADC_DW-1:0];
          default : ;  // id and unknown offsets ignore writes
        endcase
      end
    end
  end

  // read word captured with the ack
  always_ff @(posedge adc_clk)
  begin
    if (acc)
      dat_o <= rd_mux;
  end

endmodule

// File: verilog/adc_frontend.sv
// ADC input stage. Registers the raw negative-slope offset-binary samples and
// turns them into two's complement; digital loopback swaps in the DAC value.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module adc_frontend
  import pitaya_pkg::*;
(
  input  logic                adc_clk,
  input  logic                rst_i,
  input  logic [`ADC_DW-1:0]  adc_dat_a_i,  // raw pins ch a
  input  logic [`ADC_DW-1:0]  adc_dat_b_i,  // raw pins ch b
  input  logic                loop_en_i,
  input  adc_smp_t            loop_a_i,     // saturated DAC value
  input  adc_smp_t            loop_b_i,
  output adc_smp_t            adc_a_o,
  output adc_smp_t            adc_b_o
);

  logic [`ADC_DW-1:0] raw_a;
  logic [`ADC_DW-1:0] raw_b;

  // input register, the one cycle of the front end
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_a <= `NS_ZERO;  // reads as 0 after conversion
      raw_b <= `NS_ZERO;
    end
    else
    begin
      raw_a <= adc_dat_a_i;
      raw_b <= adc_dat_b_i;
    end
  end

  assign adc_a_o = loop_en_i ? loop_a_i : ns_flip(raw_a);
  assign adc_b_o = loop_en_i ? loop_b_i : ns_flip(raw_b);

endmodule

// File: verilog/p_controller.sv
// Region 1 two-channel proportional controller. Setpoint and gain registers,
// then per channel a two-stage pipeline: error, then scaled and clamped product.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module p_controller
  import pitaya_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [`BUS_AW-1:0]    adr_i,
  input  logic [`BUS_DW/8-1:0]  sel_i,
  input  logic [`BUS_DW-1:0]    dat_i,
  output logic [`BUS_DW-1:0]    dat_o,
  output logic                  ack_o,
  input  adc_smp_t              in_a_i,
  input  adc_smp_t              in_b_i,
  output adc_smp_t              out_a_o,
  output adc_smp_t              out_b_o
);

  localparam int PW = `ADC_DW + 1 + `KP_W;  // error times gain

  ctrl_reg_e                offs;
  logic                     acc;      // first cycle of an access
  logic [`BUS_DW-1:0]       rd_mux;
  logic [`BUS_DW-1:0]       wr_val;
  adc_smp_t                 sp_a, sp_b;
  logic signed [`KP_W-1:0]  kp_a, kp_b;
  adc_smp_t                 sp_v [2]; // per channel views for the pipeline
  adc_smp_t                 in_v [2];
  logic signed [`KP_W-1:0]  kp_v [2];

  assign offs = ctrl_reg_e'(adr_i[`REGION_LO-1:0]);
  assign acc  = stb_i & ~ack_o;

  always_comb
  begin
    rd_mux = '0;
    case (offs)
      CTRL_SP_A : rd_mux = {{(`BUS_DW-`ADC_DW){sp_a[`ADC_DW-1]}}, sp_a};
      CTRL_SP_B : rd_mux = {{(`BUS_DW-`ADC_DW){sp_b[`ADC_DW-1]}}, sp_b};
      CTRL_KP_A : rd_mux = {{(`BUS_DW-`KP_W){kp_a[`KP_W-1]}}, kp_a};
      CTRL_KP_B : rd_mux = {{(`BUS_DW-`KP_W){kp_b[`KP_W-1]}}, kp_b};
      default   : rd_mux = '0;
    endcase
  end

  assign wr_val = be_merge(rd_mux, dat_i, sel_i);

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o <= 1'b0;
      sp_a  <= '0;
      sp_b  <= '0;
      kp_a  <= '0;
      kp_b  <= '0;
    end
    else
    begin
      ack_o <= acc;
      if (acc && we_i)
      begin
        case (offs)
          CTRL_SP_A : sp_a <= wr_val[`ADC_DW-1:0];
          CTRL_SP_B : sp_b <= wr_val[`ADC_DW-1:0];
          CTRL_KP_A : kp_a <= wr_val[`KP_W-1:0];
          CTRL_KP_B : kp_b <= wr_val[`KP_W-1:0];
          default   : ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (acc)
      dat_o <= rd_mux;
  end

  ////////////////////////////////////////////////////////////
  // proportional pipeline
  ////////////////////////////////////////////////////////////

  assign sp_v[0] = sp_a;
  assign sp_v[1] = sp_b;
  assign kp_v[0] = kp_a;
  assign kp_v[1] = kp_b;
  assign in_v[0] = in_a_i;
  assign in_v[1] = in_b_i;

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    dac_sum_t             err_q;  // stage 1
    adc_smp_t             out_q;  // stage 2
    logic signed [PW-1:0] prod;
    logic signed [PW-1:0] shr;
    logic                 ovf;

    assign prod = err_q * kp_v[ch];
    assign shr  = prod >>> `KP_SHIFT;
    // fits only if everything above the sample msb copies the sign
    assign ovf  = ~((&shr[PW-1:`ADC_DW-1]) | ~(|shr[PW-1:`ADC_DW-1]));

    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
      begin
        err_q <= '0;
        out_q <= '0;
      end
      else
      begin
        err_q <= sp_v[ch] - in_v[ch];
        out_q <= ovf ? {shr[PW-1], {(`ADC_DW-1){~shr[PW-1]}}} : shr[`ADC_DW-1:0];
      end
    end
  end

  assign out_a_o = g_ch[0].out_q;
  assign out_b_o = g_ch[1].out_q;

endmodule

// File: verilog/dac_backend.sv
// DAC output stage. Adds the DC level to the controller output, clamps to the
// sample range and registers the negative-slope offset-binary DAC words.
// The clamped sum is also handed back for digital loopback.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module dac_backend
  import pitaya_pkg::*;
(
  input  logic                adc_clk,
  input  logic                rst_i,
  input  adc_smp_t            dc_a_i,       // DC level from housekeeping
  input  adc_smp_t            dc_b_i,
  input  adc_smp_t            ctrl_a_i,     // controller output
  input  adc_smp_t            ctrl_b_i,
  output adc_smp_t            sat_a_o,      // to loopback
  output adc_smp_t            sat_b_o,
  output logic [`ADC_DW-1:0]  dac_dat_a_o,
  output logic [`ADC_DW-1:0]  dac_dat_b_o
);

  dac_sum_t sum_a;
  dac_sum_t sum_b;

  // clamp when guard and sign bit disagree
  function automatic adc_smp_t sat_sum(input dac_sum_t s);
    if (s[`ADC_DW] ^ s[`ADC_DW-1])
      return {s[`ADC_DW], {(`ADC_DW-1){~s[`ADC_DW]}}};
    return s[`ADC_DW-1:0];
  endfunction

  assign sum_a   = dc_a_i + ctrl_a_i;  // sign extended to 15 bits
  assign sum_b   = dc_b_i + ctrl_b_i;
  assign sat_a_o = sat_sum(sum_a);
  assign sat_b_o = sat_sum(sum_b);

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= `NS_ZERO;  // mid scale
      dac_dat_b_o <= `NS_ZERO;
    end
    else
    begin
      dac_dat_a_o <= ns_flip(sat_a_o);
      dac_dat_b_o <= ns_flip(sat_b_o);
    end
  end

endmodule

// File: verilog/pitaya_top.sv
// Top level of the dual-channel ADC/DAC path. A Wishbone classic slave port
// reaches housekeeping (region 0) and the proportional controller (region 1).
// ADC pin to DAC word latency is 4 adc_clk edges.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module pitaya_top
  import pitaya_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  rst_i,
  // Wishbone slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`BUS_AW-1:0]    wb_adr_i,
  input  logic [`BUS_DW/8-1:0]  wb_sel_i,
  input  logic [`BUS_DW-1:0]    wb_dat_i,
  output logic [`BUS_DW-1:0]    wb_dat_o,
  output logic                  wb_ack_o,
  // converters
  input  logic [`ADC_DW-1:0]    adc_dat_a_i,
  input  logic [`ADC_DW-1:0]    adc_dat_b_i,
  output logic [`ADC_DW-1:0]    dac_dat_a_o,
  output logic [`ADC_DW-1:0]    dac_dat_b_o,
  output logic [`LED_W-1:0]     led_o
);

  logic [1:0]               slv_stb;    // [0] housekeeping, [1] controller
  logic [1:0]               slv_ack;
  logic [1:0][`BUS_DW-1:0]  slv_rdata;

  logic     loop_en;
  adc_smp_t dc_a, dc_b;     // DC levels
  adc_smp_t adc_a, adc_b;   // two's complement samples
  adc_smp_t pc_a, pc_b;     // controller out
  adc_smp_t sat_a, sat_b;   // clamped DAC value

  ////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////

  sys_bus_decoder sys_bus_decoder_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_adr_i    (wb_adr_i),
    .slv_ack_i   (slv_ack),
    .slv_rdata_i (slv_rdata),
    .slv_stb_o   (slv_stb),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o)
  );

  housekeeping housekeeping_i (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .stb_i     (slv_stb[0]),
    .we_i      (wb_we_i),
    .adr_i     (wb_adr_i),
    .sel_i     (wb_sel_i),
    .dat_i     (wb_dat_i),
    .dat_o     (slv_rdata[0]),
    .ack_o     (slv_ack[0]),
    .led_o     (led_o),
    .loop_en_o (loop_en),
    .dc_a_o    (dc_a),
    .dc_b_o    (dc_b)
  );

  ////////////////////////////////////////////////////////////
  // signal path
  ////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_a_i    (sat_a),
    .loop_b_i    (sat_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  p_controller p_controller_i (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .stb_i   (slv_stb[1]),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i),
    .sel_i   (wb_sel_i),
    .dat_i   (wb_dat_i),
    .dat_o   (slv_rdata[1]),
    .ack_o   (slv_ack[1]),
    .in_a_i  (adc_a),
    .in_b_i  (adc_b),
    .out_a_o (pc_a),
    .out_b_o (pc_b)
  );

  dac_backend dac_backend_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .dc_a_i      (dc_a),
    .dc_b_i      (dc_b),
    .ctrl_a_i    (pc_a),
    .ctrl_b_i    (pc_b),
    .sat_a_o     (sat_a),
    .sat_b_o     (sat_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// Free-running adc_clk and a synchronous reset pulse for the testbench.
// Reset is high from time 0 and drops on a rising edge after RST_CYCLES.
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 8
) (
  output logic adc_clk,
  output logic rst_o
);

  initial
  begin
    adc_clk = 1'b0;
    forever #(PERIOD_NS/2) adc_clk = ~adc_clk;  // 50 MHz
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_o <= 1'b0;  // released on an edge, sync reset
  end

endmodule

// File: testbench/tb_pitaya_top.sv
// Testbench for the ADC/DAC top level. Acts as the only Wishbone master, checks
// register access in all regions, then walks a table of signal path cases.
// Expected DAC words come from a small arithmetic model of the path.
`timescale 1ns/1ns
`include "pitaya_cfg.svh"

module tb_pitaya_top
  import pitaya_pkg::*;
();

  localparam int N_FIX       = 16;               // hand-picked rows
  localparam int N_RAND      = 8;                // rows with random words
  localparam int N_ROWS      = N_FIX + N_RAND;
  localparam int ACK_LIMIT   = 16;               // cycles before giving up on ack
  localparam int PIPE_EDGES  = 4;                // pin to DAC word
  localparam int LOOP_SETTLE = 60;
  localparam int WDOG_CYCLES = N_ROWS * 200;

  localparam logic [31:0] REG0_BASE = 32'h0000_0000;  // housekeeping
  localparam logic [31:0] REG1_BASE = 32'h0010_0000;  // controller

  typedef struct {
    int kind;   // 0 dc, 1 gain, 2 saturation, 3 loopback, 4 random
    int dc;
    int sp;
    int kp;
    int lp;
    int raw_a;  // ADC pin words
    int raw_b;
    int exp_a;  // DAC words
    int exp_b;
  } row_t;

  row_t tbl [N_ROWS];
  int   n_rows;
  int   err_cnt;
  int   chk_cnt;
  int   test_no;
  int   seed;

  logic                  adc_clk;
  logic                  rst;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`BUS_AW-1:0]    wb_adr;
  logic [`BUS_DW/8-1:0]  wb_sel;
  logic [`BUS_DW-1:0]    wb_wdat;
  logic [`BUS_DW-1:0]    wb_rdat;
  logic                  wb_ack;
  logic [`ADC_DW-1:0]    adc_a;
  logic [`ADC_DW-1:0]    adc_b;
  logic [`ADC_DW-1:0]    dac_a;
  logic [`ADC_DW-1:0]    dac_b;
  logic [`LED_W-1:0]     led;

  tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(8)) tb_clock_gen_i (
    .adc_clk (adc_clk),
    .rst_o   (rst)
  );

  pitaya_top pitaya_top_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_sel_i    (wb_sel),
    .wb_dat_i    (wb_wdat),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  ////////////////////////////////////////////////////////////
  // reference model of the sample path
  ////////////////////////////////////////////////////////////

  // negative slope, raw 0x1FFF is zero and raw grows as value falls
  function automatic int ns_to_val(input int raw);
    return 8191 - raw;
  endfunction

  function automatic int val_to_ns(input int v);
    return 8191 - v;
  endfunction

  function automatic int clamp14(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic int p_term(input int sp, input int kp, input int x);
    int err;
    err = sp - x;                       // fits 15 bits, no wrap
    return clamp14((err * kp) >>> 8);   // floor division by 256
  endfunction

  function automatic int expect_dac(input int dc, input int sp, input int kp,
                                    input int lp, input int raw);
    if (lp != 0)
      return val_to_ns(clamp14(dc));    // loop settles on the DC level
    return val_to_ns(clamp14(dc + p_term(sp, kp, ns_to_val(raw))));
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      0       : return "dc level";
      1       : return "gain";
      2       : return "saturation";
      3       : return "loopback";
      default : return "random";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and reporting
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("FAIL %0t ns %s got 0x%h expected 0x%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_no++;
    $display("test %0d %s: %s", test_no, name,
             (err_cnt == err_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone classic master
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, input logic [3:0] sel,
                            output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    wb_sel  <= sel;
    @(negedge adc_clk);                 // sample mid cycle
    while (!wb_ack && waited < ACK_LIMIT)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!wb_ack)
    begin
      $display("no acknowledge for access at address 0x%h", adr);
      err_cnt++;
    end
    else
      check_val("wb_ack_o latency", waited, 1);  // one cycle after first edge
    rdat = wb_rdat;
    @(posedge adc_clk);
    wb_cyc <= 1'b0;                     // stb low for at least one cycle
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat,
                          input logic [3:0] sel);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdat, sel, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
    bus_access(1'b0, adr, 32'h0, 4'hF, rdat);
  endtask

  task automatic read_expect(input logic [31:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_read(adr, rd);
    check_val($sformatf("wb_dat_o @0x%h", adr), rd, exp);
  endtask

  task automatic write_readback(input logic [31:0] adr, input logic [31:0] wdat,
                                input logic [3:0] sel, input logic [31:0] exp);
    wb_write(adr, wdat, sel);
    read_expect(adr, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input int kind, input int dc, input int sp, input int kp,
                         input int lp, input int raw_a, input int raw_b);
    tbl[n_rows].kind  = kind;
    tbl[n_rows].dc    = dc;
    tbl[n_rows].sp    = sp;
    tbl[n_rows].kp    = kp;
    tbl[n_rows].lp    = lp;
    tbl[n_rows].raw_a = raw_a;
    tbl[n_rows].raw_b = raw_b;
    tbl[n_rows].exp_a = expect_dac(dc, sp, kp, lp, raw_a);
    tbl[n_rows].exp_b = expect_dac(dc, sp, kp, lp, raw_b);
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    // gain 0, DC level over the full range
    add_row(0, -8192, 0, 0, 0, 'h0000, 'h3FFF);
    add_row(0,    -1, 0, 0, 0, 'h1234, 'h2345);
    add_row(0,     0, 0, 0, 0, 'h0000, 'h1FFF);
    add_row(0,     1, 0, 0, 0, 'h3FFF, 'h0001);
    add_row(0,  8191, 0, 0, 0, 'h2AAA, 'h1555);
    add_row(0,  2730, 0, 0, 0, 'h0F0F, 'h30F0);
    // proportional term
    add_row(1,     0,     0,  256, 0, 'h1F9B, 'h2063);  // unity gain
    add_row(1,   500,  1000,   64, 0, 'h0000, 'h3FFF);
    add_row(1,  -300, -2000, -128, 0, 'h1234, 'h2ABC);
    add_row(1,     0,     3,    1, 0, 'h1FFF, 'h1FF0);  // floor of small products
    // clamp at both ends
    add_row(2,  8000,  8000, 2047, 0, 'h3F3F, 'h3FFF);
    add_row(2, -8000, -8000, 2047, 0, 'h00BF, 'h0000);
    add_row(2,  8191,     0, -2048, 0, 'h0000, 'h1000);
    // digital loopback, setpoint at the DC level
    add_row(3,  1234,  1234, 16, 1, 'h0000, 'h3FFF);
    add_row(3, -4321, -4321, 16, 1, 'h2AAA, 'h1555);
    add_row(3,  8191,  8191, 16, 1, 'h1FFF, 'h0123);
    for (int i = 0; i < N_RAND; i++)
    begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      add_row(4, int'($signed(r0[13:0])), int'($signed(r0[27:14])),
              int'($signed(r1[11:0])), 0, int'(r1[25:12]), int'(r2[13:0]));
    end
  endtask

  task automatic apply_row(input int i);
    wb_write(REG0_BASE | 32'(HK_DC_A),   tbl[i].dc, 4'hF);
    wb_write(REG0_BASE | 32'(HK_DC_B),   tbl[i].dc, 4'hF);
    wb_write(REG1_BASE | 32'(CTRL_SP_A), tbl[i].sp, 4'hF);
    wb_write(REG1_BASE | 32'(CTRL_SP_B), tbl[i].sp, 4'hF);
    wb_write(REG1_BASE | 32'(CTRL_KP_A), tbl[i].kp, 4'hF);
    wb_write(REG1_BASE | 32'(CTRL_KP_B), tbl[i].kp, 4'hF);
    wb_write(REG0_BASE | 32'(HK_LOOP),   tbl[i].lp, 4'hF);
    @(posedge adc_clk);
    adc_a <= 14'(tbl[i].raw_a);
    adc_b <= 14'(tbl[i].raw_b);
    repeat ((tbl[i].lp != 0) ? LOOP_SETTLE : PIPE_EDGES) @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_dat_a_o", 32'(dac_a), tbl[i].exp_a);
    check_val("dac_dat_b_o", 32'(dac_b), tbl[i].exp_b);
    if (tbl[i].lp != 0)
    begin
      @(posedge adc_clk);
      adc_a <= ~adc_a;                  // pins must not matter in loopback
      adc_b <= ~adc_b;
      repeat (PIPE_EDGES) @(posedge adc_clk);
      @(negedge adc_clk);
      check_val("dac_dat_a_o", 32'(dac_a), tbl[i].exp_a);
      check_val("dac_dat_b_o", 32'(dac_b), tbl[i].exp_b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    int e0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_sel  = '0;
    wb_wdat = '0;
    adc_a   = 14'h1FFF;                 // zero in offset binary
    adc_b   = 14'h1FFF;
    seed    = 84778;
    n_rows  = 0;
    err_cnt = 0;
    chk_cnt = 0;
    test_no = 0;
    build_table();
    @(negedge rst);                     // release comes on a clock edge

    // register map, byte lanes, reset values
    e0 = err_cnt;
    @(negedge adc_clk);
    check_val("wb_ack_o", 32'(wb_ack), 0);
    check_val("led_o", 32'(led), 0);
    check_val("dac_dat_a_o", 32'(dac_a), 32'h1FFF);
    check_val("dac_dat_b_o", 32'(dac_b), 32'h1FFF);
    read_expect(REG0_BASE | 32'(HK_ID), 32'h0000_0001);
    write_readback(REG0_BASE | 32'(HK_ID), 32'hFFFF_FFFF, 4'hF, 32'h0000_0001);
    write_readback(REG0_BASE | 32'(HK_LED), 32'h0000_005A, 4'hF, 32'h0000_005A);
    check_val("led_o", 32'(led), 32'h5A);
    write_readback(REG0_BASE | 32'(HK_LED), 32'h0000_00FF, 4'b0010, 32'h0000_005A);
    check_val("led_o", 32'(led), 32'h5A);
    write_readback(REG0_BASE | 32'(HK_LOOP), 32'h0000_0003, 4'hF, 32'h0000_0001);
    write_readback(REG0_BASE | 32'(HK_LOOP), 32'h0000_0000, 4'hF, 32'h0000_0000);
    write_readback(REG0_BASE | 32'(HK_DC_A), 32'h0000_2ABC, 4'hF, 32'hFFFF_EABC);
    write_readback(REG0_BASE | 32'(HK_DC_B), 32'h0000_1234, 4'hF, 32'h0000_1234);
    write_readback(REG0_BASE | 32'(HK_DC_B), 32'hFFFF_FF56, 4'b0001, 32'h0000_1256);
    write_readback(REG0_BASE | 32'(HK_DC_B), 32'h0000_2A00, 4'b0010, 32'hFFFF_EA56);
    write_readback(REG0_BASE | 32'h14, 32'h1234_5678, 4'hF, 32'h0);  // no register
    write_readback(REG1_BASE | 32'(CTRL_SP_A), 32'h0000_1FFF, 4'hF, 32'h0000_1FFF);
    write_readback(REG1_BASE | 32'(CTRL_SP_B), 32'h0000_2000, 4'hF, 32'hFFFF_E000);
    write_readback(REG1_BASE | 32'(CTRL_KP_B), 32'h0000_0800, 4'hF, 32'hFFFF_F800);
    write_readback(REG1_BASE | 32'(CTRL_KP_A), 32'h0000_0123, 4'hF, 32'h0000_0123);
    write_readback(REG1_BASE | 32'(CTRL_KP_A), 32'hABCD_EF45, 4'b0001, 32'h0000_0145);
    write_readback(REG1_BASE | 32'h40, 32'hFFFF_FFFF, 4'hF, 32'h0);
    end_test("registers", e0);

    // regions 2..7, acked and empty, live regions untouched
    e0 = err_cnt;
    for (int r = 2; r < `N_REGIONS; r++)
      write_readback((32'(r) << `REGION_LO) | 32'h8, 32'hDEAD_BEEF, 4'hF, 32'h0);
    read_expect(REG0_BASE | 32'(HK_LED), 32'h0000_005A);
    read_expect(REG1_BASE | 32'(CTRL_KP_A), 32'h0000_0145);
    end_test("unused regions", e0);

    for (int i = 0; i < n_rows; i++)
    begin
      e0 = err_cnt;
      apply_row(i);
      end_test(kind_name(tbl[i].kind), e0);
    end

    $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // run length bound, scaled by the table
  initial
  begin : watchdog
    repeat (WDOG_CYCLES) @(posedge adc_clk);
    $display("watchdog expired after %0d cycles, run did not finish", WDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/pitaya_pkg.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping.sv
verilog/adc_frontend.sv
verilog/p_controller.sv
verilog/dac_backend.sv
verilog/pitaya_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pitaya_top.sv

// File: Makefile
# Verilator build and run for the ADC/DAC project.
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_pitaya_top
RTL_TOP   ?= pitaya_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the pass line in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
